// File: gat_macros.svh
`ifndef GAT_MACROS_SVH
`define GAT_MACROS_SVH

// Layer shape
`define GAT_NUM_FEAT_IN   8
`define GAT_NUM_FEAT_OUT  4

// Element widths
`define GAT_DATA_WIDTH    8
`define GAT_WH_WIDTH      19
`define GAT_COEF_WIDTH    32

// W entries, then a_src, then a_dst
`define GAT_WEIGHT_DEPTH  40

// Run length and output buffering
`define GAT_NUM_NODES     16
`define GAT_COEF_DEPTH    16

// LeakyReLU slope for negative inputs
`define GAT_LEAKY_SHIFT   3

`endif

// File: gat_pkg.sv
`include "gat_macros.svh"

package gat_pkg;

  // Feature, weight and attention element
  typedef logic signed [`GAT_DATA_WIDTH-1:0] elem_t;

  // Element 0 sits in the low byte
  typedef elem_t [`GAT_NUM_FEAT_IN-1:0] feat_vec_t;

  // Projected node, one signed slice per output feature
  typedef logic [`GAT_NUM_FEAT_OUT-1:0][`GAT_WH_WIDTH-1:0] wh_vec_t;

  typedef logic signed [`GAT_COEF_WIDTH-1:0] coef_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    LOAD  = 2'd1,
    RUN   = 2'd2,
    DRAIN = 2'd3
  } ctrl_state_t;

endpackage

// File: gat_load_counter.sv
module gat_load_counter #(
  parameter int LIMIT = 40
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     clear_i,
  input  logic                     inc_i,
  output logic [$clog2(LIMIT)-1:0] count_o,
  output logic                     last_o
);

  localparam int CW = $clog2(LIMIT);

  logic [CW-1:0] count_q;
  logic          at_end;

  assign at_end  = (count_q == CW'(LIMIT - 1));
  assign last_o  = inc_i && at_end;
  assign count_o = count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (inc_i) begin
      // Wrap so the next run starts at entry 0 as well
      if (at_end) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

// File: gat_layer_ctrl.sv
module gat_layer_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  logic wgt_vld_i,
  input  logic node_vld_i,
  input  logic wgt_last_i,
  input  logic node_last_i,
  input  logic pipe_busy_i,
  output logic wgt_inc_o,
  output logic node_inc_o,
  output logic cnt_clear_o,
  output logic ready_o,
  output logic done_o
);

  import gat_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  // Strobes count only in their own phase
  assign cnt_clear_o = (state == IDLE) && start_i;
  assign wgt_inc_o   = (state == LOAD) && wgt_vld_i;
  assign node_inc_o  = (state == RUN) && node_vld_i;
  assign ready_o     = (state == RUN);
  assign done_o      = (state == DRAIN) && !pipe_busy_i;

  always_comb begin
    state_nxt = state;
    unique case (state)
      IDLE: begin
        if (start_i) state_nxt = LOAD;
      end
      LOAD: begin
        if (wgt_last_i) state_nxt = RUN;
      end
      RUN: begin
        if (node_last_i) state_nxt = DRAIN;
      end
      DRAIN: begin
        // Wait for the last coefficient to reach the FIFO
        if (!pipe_busy_i) state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // At most three nodes are in flight when DRAIN begins
  a_drain_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(state == DRAIN) |-> ##[0:3] done_o)
    else $error("pipeline still busy three cycles after entering DRAIN");

endmodule

// File: gat_weight_store.sv
`include "gat_macros.svh"

module gat_weight_store (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    wr_i,
  input  logic [$clog2(`GAT_WEIGHT_DEPTH)-1:0]    addr_i,
  input  gat_pkg::elem_t                          data_i,
  output gat_pkg::elem_t [`GAT_NUM_FEAT_IN-1:0][`GAT_NUM_FEAT_OUT-1:0] w_o,
  output gat_pkg::elem_t [`GAT_NUM_FEAT_OUT-1:0]  a_src_o,
  output gat_pkg::elem_t [`GAT_NUM_FEAT_OUT-1:0]  a_dst_o
);

  import gat_pkg::*;

  localparam int NI = `GAT_NUM_FEAT_IN;
  localparam int NO = `GAT_NUM_FEAT_OUT;
  localparam int AW = $clog2(`GAT_WEIGHT_DEPTH);

  elem_t [NI-1:0][NO-1:0] w_q;
  elem_t [NO-1:0]         a_src_q;
  elem_t [NO-1:0]         a_dst_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_q     <= '0;
      a_src_q <= '0;
      a_dst_q <= '0;
    end else if (wr_i) begin
      // W is row-major by input feature
      for (int i = 0; i < NI; i++) begin
        for (int o = 0; o < NO; o++) begin
          if (addr_i == AW'(i * NO + o)) w_q[i][o] <= data_i;
        end
      end
      // Attention halves follow W
      for (int o = 0; o < NO; o++) begin
        if (addr_i == AW'(NI * NO + o)) a_src_q[o] <= data_i;
        if (addr_i == AW'(NI * NO + NO + o)) a_dst_q[o] <= data_i;
      end
    end
  end

  assign w_o     = w_q;
  assign a_src_o = a_src_q;
  assign a_dst_o = a_dst_q;

endmodule

// File: gat_node_projection.sv
`include "gat_macros.svh"

module gat_node_projection (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                vld_i,
  input  logic                target_i,
  input  gat_pkg::feat_vec_t  feat_i,
  input  gat_pkg::elem_t [`GAT_NUM_FEAT_IN-1:0][`GAT_NUM_FEAT_OUT-1:0] w_i,
  output gat_pkg::wh_vec_t    wh_o,
  output logic                vld_o,
  output logic                target_o
);

  import gat_pkg::*;

  wh_vec_t wh_d;

  // Four dot products of length eight, all in parallel
  always_comb begin
    logic signed [`GAT_WH_WIDTH-1:0] sum;
    for (int o = 0; o < `GAT_NUM_FEAT_OUT; o++) begin
      sum = '0;
      for (int i = 0; i < `GAT_NUM_FEAT_IN; i++) begin
        sum = sum + feat_i[i] * w_i[i][o];
      end
      wh_d[o] = sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_o <= 1'b0;
    end else begin
      vld_o <= vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_i) begin
      wh_o     <= wh_d;
      target_o <= target_i;
    end
  end

endmodule

// File: gat_attention_score.sv
`include "gat_macros.svh"

module gat_attention_score (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   vld_i,
  input  logic                                   target_i,
  input  gat_pkg::wh_vec_t                       wh_i,
  input  gat_pkg::elem_t [`GAT_NUM_FEAT_OUT-1:0] a_src_i,
  input  gat_pkg::elem_t [`GAT_NUM_FEAT_OUT-1:0] a_dst_i,
  output gat_pkg::coef_t                         coef_o,
  output logic                                   coef_wr_o,
  output logic                                   busy_o
);

  import gat_pkg::*;

  coef_t src_d;
  coef_t dst_d;
  logic  s1_vld;
  logic  s1_target;
  coef_t s1_src;
  coef_t s1_dst;
  coef_t tgt_q;
  coef_t tgt_sel;
  coef_t sum;
  coef_t leaky;

  always_comb begin
    src_d = '0;
    dst_d = '0;
    for (int o = 0; o < `GAT_NUM_FEAT_OUT; o++) begin
      src_d = src_d + $signed(wh_i[o]) * a_src_i[o];
      dst_d = dst_d + $signed(wh_i[o]) * a_dst_i[o];
    end
  end

  // A target node scores against itself
  assign tgt_sel = s1_target ? s1_src : tgt_q;
  assign sum     = tgt_sel + s1_dst;
  assign leaky   = sum[`GAT_COEF_WIDTH-1] ? (sum >>> `GAT_LEAKY_SHIFT) : sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld    <= 1'b0;
      coef_wr_o <= 1'b0;
      tgt_q     <= '0;
    end else begin
      s1_vld    <= vld_i;
      coef_wr_o <= s1_vld;
      if (s1_vld && s1_target) tgt_q <= s1_src;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_i) begin
      s1_target <= target_i;
      s1_src    <= src_d;
      s1_dst    <= dst_d;
    end
    if (s1_vld) coef_o <= leaky;
  end

  // Projection output counts as the entry of stage one
  assign busy_o = vld_i || s1_vld || coef_wr_o;

endmodule

// File: gat_coef_fifo.sv
`include "gat_macros.svh"

module gat_coef_fifo #(
  parameter int DEPTH = `GAT_COEF_DEPTH
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr_i,
  input  gat_pkg::coef_t din_i,
  input  logic           rd_i,
  output gat_pkg::coef_t dout_o,
  output logic           empty_o
);

  import gat_pkg::*;

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  coef_t         mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;

  assign empty_o = (count == '0);
  assign full    = (count == CW'(DEPTH));
  // Head is always on the output
  assign dout_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_i) mem[wr_ptr] <= din_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_i) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_i && !rd_i) begin
        count <= count + 1'b1;
      end else if (rd_i && !wr_i) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_i |-> !full)
    else $error("coefficient FIFO written while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_i |-> !empty_o)
    else $error("coefficient FIFO read while empty");

endmodule

// File: gat_conv_top.sv
`include "gat_macros.svh"

module gat_conv_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  input  logic               wgt_vld_i,
  input  gat_pkg::elem_t     wgt_data_i,
  input  logic               node_vld_i,
  input  gat_pkg::feat_vec_t node_feat_i,
  input  logic               node_target_i,
  input  logic               coef_rd_i,
  output logic               ready_o,
  output logic               done_o,
  output gat_pkg::coef_t     coef_data_o,
  output logic               coef_empty_o
);

  import gat_pkg::*;

  logic                                       wgt_inc;
  logic                                       node_inc;
  logic                                       cnt_clear;
  logic                                       wgt_last;
  logic                                       node_last;
  logic [$clog2(`GAT_WEIGHT_DEPTH)-1:0]       wgt_addr;
  elem_t [`GAT_NUM_FEAT_IN-1:0][`GAT_NUM_FEAT_OUT-1:0] w;
  elem_t [`GAT_NUM_FEAT_OUT-1:0]              a_src;
  elem_t [`GAT_NUM_FEAT_OUT-1:0]              a_dst;
  wh_vec_t                                    wh;
  logic                                       wh_vld;
  logic                                       wh_target;
  coef_t                                      coef;
  logic                                       coef_wr;
  logic                                       pipe_busy;

  gat_layer_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .wgt_vld_i   (wgt_vld_i),
    .node_vld_i  (node_vld_i),
    .wgt_last_i  (wgt_last),
    .node_last_i (node_last),
    .pipe_busy_i (pipe_busy),
    .wgt_inc_o   (wgt_inc),
    .node_inc_o  (node_inc),
    .cnt_clear_o (cnt_clear),
    .ready_o     (ready_o),
    .done_o      (done_o)
  );

  gat_load_counter #(.LIMIT(`GAT_WEIGHT_DEPTH)) u_wgt_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear_i (cnt_clear),
    .inc_i   (wgt_inc),
    .count_o (wgt_addr),
    .last_o  (wgt_last)
  );

  // Only the terminal flag matters for nodes
  gat_load_counter #(.LIMIT(`GAT_NUM_NODES)) u_node_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear_i (cnt_clear),
    .inc_i   (node_inc),
    .count_o (),
    .last_o  (node_last)
  );

  gat_weight_store u_wgt_store (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (wgt_inc),
    .addr_i  (wgt_addr),
    .data_i  (wgt_data_i),
    .w_o     (w),
    .a_src_o (a_src),
    .a_dst_o (a_dst)
  );

  gat_node_projection u_proj (
    .clk      (clk),
    .rst_n    (rst_n),
    .vld_i    (node_inc),
    .target_i (node_target_i),
    .feat_i   (node_feat_i),
    .w_i      (w),
    .wh_o     (wh),
    .vld_o    (wh_vld),
    .target_o (wh_target)
  );

  gat_attention_score u_score (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld_i     (wh_vld),
    .target_i  (wh_target),
    .wh_i      (wh),
    .a_src_i   (a_src),
    .a_dst_i   (a_dst),
    .coef_o    (coef),
    .coef_wr_o (coef_wr),
    .busy_o    (pipe_busy)
  );

  gat_coef_fifo #(.DEPTH(`GAT_COEF_DEPTH)) u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (coef_wr),
    .din_i   (coef),
    .rd_i    (coef_rd_i),
    .dout_o  (coef_data_o),
    .empty_o (coef_empty_o)
  );

endmodule

// File: tb_gat_checker.sv
`include "gat_macros.svh"

module tb_gat_checker (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  input  logic               wgt_vld_i,
  input  gat_pkg::elem_t     wgt_data_i,
  input  logic               node_vld_i,
  input  gat_pkg::feat_vec_t node_feat_i,
  input  logic               node_target_i,
  input  logic               ready_i,
  input  logic               done_i,
  input  logic               coef_rd_i,
  input  gat_pkg::coef_t     coef_data_i,
  input  logic               coef_empty_i,
  output int                 err_cnt_o,
  output int                 chk_cnt_o,
  output int                 pending_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import gat_pkg::*;

  localparam int NI = `GAT_NUM_FEAT_IN;
  localparam int NO = `GAT_NUM_FEAT_OUT;

  longint w_ref [NI][NO];
  longint a_src_ref [NO];
  longint a_dst_ref [NO];
  longint held;
  coef_t  exp_q [$];
  logic   loading;
  logic   running;
  int     wgt_idx;
  int     node_cnt;
  logic   done_seen;

  // Target score plus own destination score, then LeakyReLU
  function automatic coef_t expected_coef(input feat_vec_t feat, input logic target);
    longint wh;
    longint src;
    longint dst;
    longint sum;
    src = 0;
    dst = 0;
    for (int o = 0; o < NO; o++) begin
      wh = 0;
      for (int i = 0; i < NI; i++) begin
        wh += longint'(feat[i]) * w_ref[i][o];
      end
      src += wh * a_src_ref[o];
      dst += wh * a_dst_ref[o];
    end
    if (target) held = src;
    sum = held + dst;
    if (sum < 0) sum = sum >>> `GAT_LEAKY_SHIFT;
    return coef_t'(sum);
  endfunction

  task automatic store_weight(input int idx, input elem_t val);
    if (idx < NI * NO) begin
      w_ref[idx / NO][idx % NO] = val;
    end else if (idx < NI * NO + NO) begin
      a_src_ref[idx - NI * NO] = val;
    end else begin
      a_dst_ref[idx - NI * NO - NO] = val;
    end
  endtask

  always @(posedge clk or negedge rst_n) begin
    coef_t exp_val;
    if (!rst_n) begin
      held      = 0;
      loading   = 1'b0;
      running   = 1'b0;
      wgt_idx   = 0;
      node_cnt  = 0;
      done_seen = 1'b0;
      err_cnt_o = 0;
      chk_cnt_o = 0;
      pending_o = 0;
      exp_q.delete();
    end else begin
      if (ready_i !== running) begin
        err_cnt_o++;
        $display("Error ready_o got %h exp %h", ready_i, running);
      end
      // Nodes count only between the last weight and the last node
      if (running && node_vld_i) begin
        exp_q.push_back(expected_coef(node_feat_i, node_target_i));
        node_cnt++;
        if (node_cnt == `GAT_NUM_NODES) running = 1'b0;
      end
      if (start_i && !loading) begin
        loading   = 1'b1;
        wgt_idx   = 0;
        node_cnt  = 0;
        done_seen = 1'b0;
      end else if (loading && wgt_vld_i) begin
        store_weight(wgt_idx, wgt_data_i);
        wgt_idx++;
        if (wgt_idx == `GAT_WEIGHT_DEPTH) begin
          loading = 1'b0;
          running = 1'b1;
        end
      end
      if (done_i) begin
        if (done_seen) begin
          err_cnt_o++;
          $display("done_o pulsed more than once in one run");
        end else if (node_cnt != `GAT_NUM_NODES) begin
          err_cnt_o++;
          $display("done_o pulsed after %0d of %0d nodes", node_cnt, `GAT_NUM_NODES);
        end
        done_seen = 1'b1;
      end
      if (coef_rd_i && !coef_empty_i) begin
        if (exp_q.size() == 0) begin
          err_cnt_o++;
          $display("A coefficient was read while no accepted node was pending");
        end else begin
          exp_val = exp_q.pop_front();
          chk_cnt_o++;
          if (coef_data_i !== exp_val) begin
            err_cnt_o++;
            $display("Error coef_data_o got %h exp %h", coef_data_i, exp_val);
          end
        end
      end
      pending_o = exp_q.size();
    end
  end

endmodule

// File: tb_gat_conv.sv
`include "gat_macros.svh"

module tb_gat_conv;

  timeunit 1ns;
  timeprecision 1ps;

  import gat_pkg::*;

  localparam int NN          = `GAT_NUM_NODES;
  localparam int NUM_TESTS   = 5;
  localparam int WATCHDOG_NS = NUM_TESTS * (`GAT_WEIGHT_DEPTH + 2 * NN + 20) * 10;

  logic      clk;
  logic      rst_n;
  logic      start_i;
  logic      wgt_vld_i;
  elem_t     wgt_data_i;
  logic      node_vld_i;
  feat_vec_t node_feat_i;
  logic      node_target_i;
  logic      coef_rd_i;
  logic      ready_o;
  logic      done_o;
  coef_t     coef_data_o;
  logic      coef_empty_o;

  elem_t     wgt_buf [`GAT_WEIGHT_DEPTH];
  feat_vec_t feat_buf [NN];
  logic      tgt_buf [NN];
  int        tb_errs;
  int        tb_checks;
  int        runs;
  int        done_pulses;
  int        chk_errs;
  int        chk_count;
  int        pending;

  gat_conv_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .wgt_vld_i     (wgt_vld_i),
    .wgt_data_i    (wgt_data_i),
    .node_vld_i    (node_vld_i),
    .node_feat_i   (node_feat_i),
    .node_target_i (node_target_i),
    .coef_rd_i     (coef_rd_i),
    .ready_o       (ready_o),
    .done_o        (done_o),
    .coef_data_o   (coef_data_o),
    .coef_empty_o  (coef_empty_o)
  );

  tb_gat_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .wgt_vld_i     (wgt_vld_i),
    .wgt_data_i    (wgt_data_i),
    .node_vld_i    (node_vld_i),
    .node_feat_i   (node_feat_i),
    .node_target_i (node_target_i),
    .ready_i       (ready_o),
    .done_i        (done_o),
    .coef_rd_i     (coef_rd_i),
    .coef_data_i   (coef_data_o),
    .coef_empty_i  (coef_empty_o),
    .err_cnt_o     (chk_errs),
    .chk_cnt_o     (chk_count),
    .pending_o     (pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with the run unfinished", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

  // Pop every other cycle so a stale empty flag never causes an underflow
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_rd_i   <= 1'b0;
      done_pulses <= 0;
    end else begin
      coef_rd_i <= !coef_empty_o && !coef_rd_i;
      if (done_o) done_pulses <= done_pulses + 1;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    tb_checks++;
    if (got !== exp) begin
      tb_errs++;
      $display("Error %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic report_test(input int num, input string name, input int base);
    if (tb_errs + chk_errs == base) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: %0d errors", num, name, tb_errs + chk_errs - base);
    end
  endtask

  task automatic random_weights();
    for (int k = 0; k < `GAT_WEIGHT_DEPTH; k++) wgt_buf[k] = elem_t'($urandom);
  endtask

  // Subgraphs of 1 to max_len nodes, each opened by a target
  task automatic random_nodes(input int max_len);
    int left;
    left = 0;
    for (int n = 0; n < NN; n++) begin
      tgt_buf[n] = (left == 0);
      if (left == 0) left = (max_len >= NN) ? NN : 1 + $urandom % max_len;
      left--;
      for (int i = 0; i < `GAT_NUM_FEAT_IN; i++) feat_buf[n][i] = elem_t'($urandom);
    end
  endtask

  task automatic load_weights();
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    for (int k = 0; k < `GAT_WEIGHT_DEPTH; k++) begin
      wgt_vld_i  <= 1'b1;
      wgt_data_i <= wgt_buf[k];
      @(posedge clk);
    end
    wgt_vld_i <= 1'b0;
    runs++;
  endtask

  task automatic send_nodes();
    @(negedge clk);
    while (!ready_o) @(negedge clk);
    for (int n = 0; n < NN; n++) begin
      @(posedge clk);
      node_vld_i    <= 1'b1;
      node_feat_i   <= feat_buf[n];
      node_target_i <= tgt_buf[n];
    end
    @(posedge clk);
    node_vld_i <= 1'b0;
  endtask

  task automatic send_stray_nodes(input int count);
    for (int n = 0; n < count; n++) begin
      @(posedge clk);
      node_vld_i    <= 1'b1;
      node_feat_i   <= feat_vec_t'({$urandom, $urandom});
      node_target_i <= n[0];
    end
    @(posedge clk);
    node_vld_i <= 1'b0;
  endtask

  task automatic wait_drained();
    @(negedge clk);
    while (done_pulses < runs || pending != 0 || !coef_empty_o) @(negedge clk);
  endtask

  initial begin
    int base;
    void'($urandom(32'h7034_ad1e));
    tb_errs       = 0;
    tb_checks     = 0;
    runs          = 0;
    rst_n         <= 1'b0;
    start_i       <= 1'b0;
    wgt_vld_i     <= 1'b0;
    wgt_data_i    <= '0;
    node_vld_i    <= 1'b0;
    node_feat_i   <= '0;
    node_target_i <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    base = tb_errs + chk_errs;
    @(negedge clk);
    check_bit("ready_o", ready_o, 1'b0);
    check_bit("done_o", done_o, 1'b0);
    check_bit("coef_empty_o", coef_empty_o, 1'b1);
    random_weights();
    load_weights();
    @(negedge clk);
    check_bit("ready_o", ready_o, 1'b1);
    report_test(1, "reset and weight load", base);

    base = tb_errs + chk_errs;
    random_nodes(NN);
    send_nodes();
    wait_drained();
    report_test(2, "single subgraph", base);

    base = tb_errs + chk_errs;
    random_weights();
    load_weights();
    random_nodes(5);
    send_nodes();
    wait_drained();
    report_test(3, "several subgraphs", base);

    // Positive W and features with negative attention give negative sums
    base = tb_errs + chk_errs;
    for (int k = 0; k < `GAT_NUM_FEAT_IN * `GAT_NUM_FEAT_OUT; k++) wgt_buf[k] = elem_t'(1 + k % 3);
    for (int o = 0; o < `GAT_NUM_FEAT_OUT; o++) begin
      wgt_buf[32 + o] = elem_t'(-1 - o);
      wgt_buf[36 + o] = elem_t'(-2 - o);
    end
    random_nodes(8);
    for (int n = 0; n < NN; n++) begin
      for (int i = 0; i < `GAT_NUM_FEAT_IN; i++) feat_buf[n][i] = elem_t'(1 + $urandom % 31);
    end
    load_weights();
    send_nodes();
    wait_drained();
    report_test(4, "negative sums", base);

    base = tb_errs + chk_errs;
    random_weights();
    load_weights();
    random_nodes(NN);
    send_nodes();
    @(negedge clk);
    check_bit("ready_o", ready_o, 1'b0);
    send_stray_nodes(3);
    wait_drained();
    send_stray_nodes(3);
    repeat (5) @(negedge clk);
    check_bit("coef_empty_o", coef_empty_o, 1'b1);
    tb_checks++;
    if (done_pulses != runs) begin
      tb_errs++;
      $display("done_o pulsed %0d times over %0d runs instead of once per run", done_pulses, runs);
    end
    random_weights();
    load_weights();
    random_nodes(6);
    send_nodes();
    wait_drained();
    report_test(5, "done, ignored nodes and reload", base);

    $display("%0d checks, %0d errors", tb_checks + chk_count, tb_errs + chk_errs);
    if (tb_errs + chk_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+.
gat_pkg.sv
gat_load_counter.sv
gat_layer_ctrl.sv
gat_weight_store.sv
gat_node_projection.sv
gat_attention_score.sv
gat_coef_fifo.sv
gat_conv_top.sv
tb_gat_checker.sv
tb_gat_conv.sv

// File: Bender.yml
package:
  name: gat_conv

sources:
  - include_dirs:
      - .
    files:
      - gat_pkg.sv
      - gat_load_counter.sv
      - gat_layer_ctrl.sv
      - gat_weight_store.sv
      - gat_node_projection.sv
      - gat_attention_score.sv
      - gat_coef_fifo.sv
      - gat_conv_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_gat_checker.sv
      - tb_gat_conv.sv
